//--- h2a_pkg.sv
package h2a_pkg;

    ////////////////////////////////////////////////////////////
    // widths and constants
    ////////////////////////////////////////////////////////////

    // descriptor and data path widths
    localparam int DSC_W      = 256;
    localparam int DATA_W     = 64;
    localparam int ADDR_W     = 64;

    // one beat is DATA_W/8 bytes, shift turns bytes into beats
    localparam int BEAT_BYTES = 8;
    localparam int BEAT_SHIFT = 3;

    // byte length field, beat count keeps LEN_W - BEAT_SHIFT bits
    localparam int LEN_W      = 28;
    localparam int CNT_W      = 25;

    // channels and completion record fields
    localparam int CH_W       = 2;
    localparam int NUM_CH     = 4;
    localparam int ID_W       = 30;

    // read id is {channel, engine id}
    localparam int AXI_ID_W   = 5;
    localparam logic [2:0] ENGINE_ID = 3'b001;

    localparam int MAGIC_W    = 16;
    localparam logic [MAGIC_W-1:0] DSC_MAGIC = 16'had4b;

    // address increment per beat
    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(BEAT_BYTES);

    // read data FIFO entries
    localparam int RDATA_DEPTH = 8;

    ////////////////////////////////////////////////////////////
    // descriptor field positions (lowest bit of each field)
    ////////////////////////////////////////////////////////////

    localparam int IRQ_BIT    = 1;
    localparam int EOP_BIT    = 4;
    localparam int MAGIC_LSB  = 16;
    localparam int LEN_LSB    = 32;
    localparam int SRC_LSB    = 64;
    localparam int ID_LSB     = 192;
    localparam int CH_LSB     = 222;

    // completion record, 99 bits
    typedef struct packed {
        logic [ADDR_W-1:0] err_addr;
        logic              irq;
        logic [CH_W-1:0]   channel;
        logic [ID_W-1:0]   dsc_id;
        logic              complete;
        logic              error;
    } cmp_rec_t;

    // read FIFO payload
    typedef logic [DATA_W-1:0] rbeat_t;

endpackage

//--- h2a_dsc_if.sv
`timescale 1ns/100ps

interface h2a_dsc_if;

    // one-cycle pulse when a valid descriptor is accepted
    logic                           start;

    // descriptor fields, stable while the descriptor is in flight
    logic [h2a_pkg::ADDR_W-1:0]     src_addr;
    logic [h2a_pkg::CNT_W-1:0]      beats;
    logic [h2a_pkg::CH_W-1:0]       channel;
    logic [h2a_pkg::ID_W-1:0]       dsc_id;
    logic                           irq;
    logic                           eop;

    // end of stream side and end of completion handshake
    logic                           stream_done;
    logic                           cmp_done;

    modport dispatch (output start, src_addr, beats, channel, dsc_id, irq, eop,
                      input  cmp_done);

    modport writer   (input  start, beats, eop,
                      output stream_done);

    modport cmp      (input  start, src_addr, beats, channel, dsc_id, irq, eop, stream_done,
                      output cmp_done);

endinterface

//--- h2a_fifo.sv
`timescale 1ns/100ps

module h2a_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     valid,
    output logic     full
);

    // pointer and occupancy widths follow DEPTH
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // wrap at DEPTH-1 so non power of two depths work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == OCC_W'(DEPTH));
    assign valid = (count != '0);

    // writes into a full FIFO and reads from an empty one are ignored
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & valid;

    // first word fall through, head is always on rd_data
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // occupancy only moves when exactly one side is active
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- h2a_rd_dispatch.sv
`timescale 1ns/100ps

module h2a_rd_dispatch (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           head_valid,
    input  logic [h2a_pkg::DSC_W-1:0]      head,
    output logic                           pop,
    h2a_dsc_if.dispatch                    dsc,
    output logic                           lcl_rd_valid,
    output logic [h2a_pkg::ADDR_W-1:0]     lcl_rd_ea,
    output logic [h2a_pkg::AXI_ID_W-1:0]   lcl_rd_axi_id,
    output logic                           lcl_rd_first,
    output logic                           lcl_rd_last,
    input  logic                           lcl_rd_ready
);

    logic                          busy;
    logic                          magic_ok;
    logic                          rd_issue;
    logic [h2a_pkg::LEN_W-1:0]     head_len;
    logic [h2a_pkg::CNT_W-1:0]     req_cnt;
    logic [h2a_pkg::CNT_W-1:0]     req_num;
    logic [h2a_pkg::ADDR_W-1:0]    req_addr;

    ////////////////////////////////////////////////////////////
    // parser
    ////////////////////////////////////////////////////////////

    // take the head whenever idle, bad magic is simply dropped
    assign pop      = head_valid & ~busy;
    assign magic_ok = (head[h2a_pkg::MAGIC_LSB +: h2a_pkg::MAGIC_W] == h2a_pkg::DSC_MAGIC);
    assign head_len = head[h2a_pkg::LEN_LSB +: h2a_pkg::LEN_W];

    // descriptor context, loaded once per accepted descriptor
    always_ff @(posedge clk) begin
        if (pop && magic_ok) begin
            dsc.src_addr <= head[h2a_pkg::SRC_LSB +: h2a_pkg::ADDR_W];
            // partial beat at the tail is truncated
            dsc.beats    <= head_len[h2a_pkg::LEN_W-1:h2a_pkg::BEAT_SHIFT];
            dsc.channel  <= head[h2a_pkg::CH_LSB +: h2a_pkg::CH_W];
            dsc.dsc_id   <= head[h2a_pkg::ID_LSB +: h2a_pkg::ID_W];
            dsc.irq      <= head[h2a_pkg::IRQ_BIT];
            dsc.eop      <= head[h2a_pkg::EOP_BIT];
        end
    end

    ////////////////////////////////////////////////////////////
    // read request dispatch
    ////////////////////////////////////////////////////////////

    assign rd_issue = lcl_rd_valid & lcl_rd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            dsc.start <= 1'b0;
            req_cnt   <= '0;
            req_num   <= '0;
            req_addr  <= '0;
        end else begin
            dsc.start <= pop & magic_ok;
            if (pop && magic_ok) begin
                busy     <= 1'b1;
                req_cnt  <= head_len[h2a_pkg::LEN_W-1:h2a_pkg::BEAT_SHIFT];
                req_num  <= head_len[h2a_pkg::LEN_W-1:h2a_pkg::BEAT_SHIFT];
                req_addr <= head[h2a_pkg::SRC_LSB +: h2a_pkg::ADDR_W];
            end else begin
                // one descriptor in flight until the host answers
                if (dsc.cmp_done) begin
                    busy <= 1'b0;
                end
                if (rd_issue) begin
                    req_cnt  <= req_cnt - 1;
                    req_addr <= req_addr + h2a_pkg::ADDR_STEP;
                end
            end
        end
    end

    // request outputs, held until the port takes them
    assign lcl_rd_valid  = (req_cnt != '0);
    assign lcl_rd_ea     = req_addr;
    assign lcl_rd_axi_id = {dsc.channel, h2a_pkg::ENGINE_ID};
    assign lcl_rd_first  = lcl_rd_valid & (req_cnt == req_num);
    assign lcl_rd_last   = (req_cnt == 1);

endmodule

//--- h2a_st_writer.sv
`timescale 1ns/100ps

module h2a_st_writer (
    input  logic                         clk,
    input  logic                         rst_n,
    h2a_dsc_if.writer                    dsc,
    input  logic                         fifo_valid,
    input  h2a_pkg::rbeat_t              fifo_data,
    output logic                         fifo_rd,
    output logic                         m_axis_tvalid,
    input  logic                         m_axis_tready,
    output logic [h2a_pkg::DATA_W-1:0]   m_axis_tdata,
    output logic                         m_axis_tlast
);

    // beats still to be sent for the active descriptor
    logic [h2a_pkg::CNT_W-1:0] beat_cnt;
    logic                      active;
    logic                      st_xfer;

    // only beats of the current descriptor leave the FIFO
    assign m_axis_tvalid = fifo_valid & (beat_cnt != '0);
    assign m_axis_tdata  = fifo_data;
    assign m_axis_tlast  = dsc.eop & (beat_cnt == 1);

    assign st_xfer = m_axis_tvalid & m_axis_tready;
    assign fifo_rd = st_xfer;

    // zero length descriptors end one cycle after start
    assign dsc.stream_done = active & (beat_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            active   <= 1'b0;
        end else begin
            if (dsc.start) begin
                beat_cnt <= dsc.beats;
                active   <= 1'b1;
            end else begin
                if (st_xfer) begin
                    beat_cnt <= beat_cnt - 1;
                end
                // single done pulse per descriptor
                if (dsc.stream_done) begin
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

//--- h2a_cmp_ctrl.sv
`timescale 1ns/100ps

module h2a_cmp_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    h2a_dsc_if.cmp                       dsc,
    input  logic                         rx_beat,
    input  logic                         rx_err,
    output logic [h2a_pkg::NUM_CH-1:0]   cmp_valid,
    output h2a_pkg::cmp_rec_t            cmp_data,
    input  logic [h2a_pkg::NUM_CH-1:0]   cmp_resp
);

    logic [h2a_pkg::ADDR_W-1:0]  rx_addr;
    logic [h2a_pkg::ADDR_W-1:0]  err_addr;
    logic                        err_flag;
    logic [h2a_pkg::NUM_CH-1:0]  ch_sel;

    ////////////////////////////////////////////////////////////
    // read error tracking
    ////////////////////////////////////////////////////////////

    // address of the beat being received, steps once per beat
    always_ff @(posedge clk) begin
        if (dsc.start) begin
            rx_addr  <= dsc.src_addr;
            err_addr <= '0;
        end else if (rx_beat) begin
            rx_addr <= rx_addr + h2a_pkg::ADDR_STEP;
            // keep the first errored beat only
            if (rx_err && !err_flag) begin
                err_addr <= rx_addr;
            end
        end
    end

    // sticky for the life of one descriptor
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_flag <= 1'b0;
        end else if (dsc.start) begin
            err_flag <= 1'b0;
        end else if (rx_beat && rx_err) begin
            err_flag <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // completion handshake
    ////////////////////////////////////////////////////////////

    always_comb begin
        ch_sel              = '0;
        ch_sel[dsc.channel] = 1'b1;
    end

    // record captured once, held until the host answers
    always_ff @(posedge clk) begin
        if (dsc.stream_done) begin
            cmp_data.err_addr <= err_addr;
            cmp_data.irq      <= dsc.irq;
            cmp_data.channel  <= dsc.channel;
            cmp_data.dsc_id   <= dsc.dsc_id;
            cmp_data.complete <= 1'b1;
            cmp_data.error    <= err_flag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_valid <= '0;
        end else if (dsc.stream_done) begin
            cmp_valid <= cmp_valid | ch_sel;
        end else begin
            cmp_valid <= cmp_valid & ~cmp_resp;
        end
    end

    // only the active channel can be valid
    assign dsc.cmp_done = |(cmp_valid & cmp_resp);

endmodule

//--- h2a_st_engine.sv
`timescale 1ns/100ps

module h2a_st_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    // descriptor input
    input  logic                           dsc_valid,
    output logic                           dsc_ready,
    input  logic [h2a_pkg::DSC_W-1:0]      dsc_data,
    // local read request
    output logic                           lcl_rd_valid,
    output logic [h2a_pkg::ADDR_W-1:0]     lcl_rd_ea,
    output logic [h2a_pkg::AXI_ID_W-1:0]   lcl_rd_axi_id,
    output logic                           lcl_rd_first,
    output logic                           lcl_rd_last,
    input  logic                           lcl_rd_ready,
    // local read data
    input  logic                           lcl_rd_data_valid,
    input  logic [h2a_pkg::DATA_W-1:0]     lcl_rd_data,
    input  logic                           lcl_rd_rsp_code,
    output logic                           lcl_rd_rsp_ready,
    // AXI4-Stream master
    output logic                           m_axis_tvalid,
    input  logic                           m_axis_tready,
    output logic [h2a_pkg::DATA_W-1:0]     m_axis_tdata,
    output logic                           m_axis_tlast,
    output logic [h2a_pkg::AXI_ID_W-1:0]   m_axis_tid,
    // completion
    output logic [h2a_pkg::NUM_CH-1:0]     cmp_valid,
    output h2a_pkg::cmp_rec_t              cmp_data,
    input  logic [h2a_pkg::NUM_CH-1:0]     cmp_resp
);

    logic                        dsc_full;
    logic                        head_valid;
    logic [h2a_pkg::DSC_W-1:0]   head;
    logic                        head_pop;
    logic                        rx_beat;
    logic                        rdata_full;
    logic                        rdata_valid;
    logic                        rdata_rd;
    h2a_pkg::rbeat_t             rdata_head;

    h2a_dsc_if dsc_bus ();

    ////////////////////////////////////////////////////////////
    // descriptor queue, two entries
    ////////////////////////////////////////////////////////////

    assign dsc_ready = ~dsc_full;

    h2a_fifo #(
        .payload_t (logic [h2a_pkg::DSC_W-1:0]),
        .DEPTH     (2)
    ) dsc_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (dsc_valid & dsc_ready),
        .wr_data (dsc_data),
        .rd_en   (head_pop),
        .rd_data (head),
        .valid   (head_valid),
        .full    (dsc_full)
    );

    h2a_rd_dispatch u_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .head          (head),
        .pop           (head_pop),
        .dsc           (dsc_bus.dispatch),
        .lcl_rd_valid  (lcl_rd_valid),
        .lcl_rd_ea     (lcl_rd_ea),
        .lcl_rd_axi_id (lcl_rd_axi_id),
        .lcl_rd_first  (lcl_rd_first),
        .lcl_rd_last   (lcl_rd_last),
        .lcl_rd_ready  (lcl_rd_ready)
    );

    ////////////////////////////////////////////////////////////
    // read data path
    ////////////////////////////////////////////////////////////

    // host only drives data valid while rsp_ready is high
    assign lcl_rd_rsp_ready = ~rdata_full;
    assign rx_beat          = lcl_rd_data_valid & lcl_rd_rsp_ready;

    h2a_fifo #(
        .payload_t (h2a_pkg::rbeat_t),
        .DEPTH     (h2a_pkg::RDATA_DEPTH)
    ) rdata_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (rx_beat),
        .wr_data (lcl_rd_data),
        .rd_en   (rdata_rd),
        .rd_data (rdata_head),
        .valid   (rdata_valid),
        .full    (rdata_full)
    );

    h2a_st_writer u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .dsc           (dsc_bus.writer),
        .fifo_valid    (rdata_valid),
        .fifo_data     (rdata_head),
        .fifo_rd       (rdata_rd),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

    // stream id carries the channel, zero extended
    assign m_axis_tid = {{(h2a_pkg::AXI_ID_W - h2a_pkg::CH_W){1'b0}}, dsc_bus.channel};

    h2a_cmp_ctrl u_cmp (
        .clk       (clk),
        .rst_n     (rst_n),
        .dsc       (dsc_bus.cmp),
        .rx_beat   (rx_beat),
        .rx_err    (lcl_rd_rsp_code),
        .cmp_valid (cmp_valid),
        .cmp_data  (cmp_data),
        .cmp_resp  (cmp_resp)
    );

endmodule

//--- h2a_st_engine_checker.sv
`timescale 1ns/100ps

module h2a_st_engine_checker (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           lcl_rd_valid,
    input logic                           lcl_rd_ready,
    input logic [h2a_pkg::ADDR_W-1:0]     lcl_rd_ea,
    input logic [h2a_pkg::AXI_ID_W-1:0]   lcl_rd_axi_id,
    input logic                           lcl_rd_first,
    input logic                           lcl_rd_last,
    input logic                           lcl_rd_data_valid,
    input logic                           lcl_rd_rsp_ready,
    input logic                           m_axis_tvalid,
    input logic                           m_axis_tready,
    input logic [h2a_pkg::DATA_W-1:0]     m_axis_tdata,
    input logic                           m_axis_tlast,
    input logic [h2a_pkg::AXI_ID_W-1:0]   m_axis_tid,
    input logic [h2a_pkg::NUM_CH-1:0]     cmp_valid
);

    // read request holds until the port takes it
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lcl_rd_valid && !lcl_rd_ready |=> lcl_rd_valid && $stable(lcl_rd_ea)
            && $stable(lcl_rd_axi_id) && $stable(lcl_rd_first) && $stable(lcl_rd_last))
        else $error("read request changed while stalled");

    // AXI4-Stream beat holds under back pressure
    st_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tlast) && $stable(m_axis_tid))
        else $error("stream beat changed while stalled");

    // one descriptor in flight, so one channel at most
    cmp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(cmp_valid))
        else $error("more than one completion valid");

    // host side rule, data only while the FIFO has room
    rsp_room: assert property (@(posedge clk) disable iff (!rst_n)
        lcl_rd_data_valid |-> lcl_rd_rsp_ready)
        else $error("read data while rsp_ready low");

endmodule

bind h2a_st_engine h2a_st_engine_checker u_checker (.*);

//--- tb_h2a_st_engine.sv
`timescale 1ns/100ps

module tb_h2a_st_engine;

    localparam int NUM_DSC = 40;
    // per-descriptor bound for 12 beats under random stalls and a slow resp
    localparam int MAX_CYC_PER_DSC = 500;
    localparam longint WATCHDOG_NS = (NUM_DSC * MAX_CYC_PER_DSC + 100) * 10;

    logic                             clk;
    logic                             rst_n;
    logic                             dsc_valid;
    logic                             dsc_ready;
    logic [h2a_pkg::DSC_W-1:0]        dsc_data;
    logic                             lcl_rd_valid;
    logic [h2a_pkg::ADDR_W-1:0]       lcl_rd_ea;
    logic [h2a_pkg::AXI_ID_W-1:0]     lcl_rd_axi_id;
    logic                             lcl_rd_first;
    logic                             lcl_rd_last;
    logic                             lcl_rd_ready;
    logic                             lcl_rd_data_valid;
    logic [h2a_pkg::DATA_W-1:0]       lcl_rd_data;
    logic                             lcl_rd_rsp_code;
    logic                             lcl_rd_rsp_ready;
    logic                             m_axis_tvalid;
    logic                             m_axis_tready;
    logic [h2a_pkg::DATA_W-1:0]       m_axis_tdata;
    logic                             m_axis_tlast;
    logic [h2a_pkg::AXI_ID_W-1:0]     m_axis_tid;
    logic [h2a_pkg::NUM_CH-1:0]       cmp_valid;
    h2a_pkg::cmp_rec_t                cmp_data;
    logic [h2a_pkg::NUM_CH-1:0]       cmp_resp;

    // reference model state with one entry per generated descriptor
    logic [h2a_pkg::DSC_W-1:0]        d_word  [NUM_DSC];
    logic [h2a_pkg::ADDR_W-1:0]       d_src   [NUM_DSC];
    int                               d_beats [NUM_DSC];
    logic [h2a_pkg::CH_W-1:0]         d_ch    [NUM_DSC];
    logic [h2a_pkg::ID_W-1:0]         d_id    [NUM_DSC];
    logic                             d_irq   [NUM_DSC];
    logic                             d_eop   [NUM_DSC];
    // indices of good descriptors in completion order
    int                               exp_q   [$];
    // accepted read requests waiting for their data beat
    logic [h2a_pkg::ADDR_W-1:0]       host_q  [$];

    int                               n_valid;
    int                               n_done;
    int                               cur;
    int                               req_k;
    int                               beat_k;
    int                               rd_occ;
    int                               stall_cyc;
    logic                             exp_err;
    logic [h2a_pkg::ADDR_W-1:0]       exp_err_addr;
    logic                             run;

    h2a_st_engine dut (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // host memory contents where every address bit feeds the word
    function automatic logic [63:0] mem_word(input logic [63:0] addr);
        return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], addr[63:32]};
    endfunction

    task automatic make_descriptors();
        logic [h2a_pkg::DSC_W-1:0]   word;
        logic [h2a_pkg::MAGIC_W-1:0] magic;
        int                          i;
        int                          w;
        for (i = 0; i < NUM_DSC; i++) begin
            // unused bits carry noise
            for (w = 0; w < h2a_pkg::DSC_W / 32; w++) begin
                word[w*32 +: 32] = $urandom;
            end
            d_src[i]   = {$urandom, $urandom} & ~64'(h2a_pkg::BEAT_BYTES - 1);
            // descriptor 5 is always a good zero length one
            d_beats[i] = (i == 5) ? 0 : int'($urandom % 13);
            d_ch[i]    = h2a_pkg::CH_W'($urandom);
            d_id[i]    = h2a_pkg::ID_W'($urandom);
            d_irq[i]   = 1'($urandom);
            d_eop[i]   = 1'($urandom);
            magic      = h2a_pkg::DSC_MAGIC;
            if (i != 5 && $urandom % 8 == 0) begin
                // xor with a nonzero value so the magic is always wrong
                magic = h2a_pkg::DSC_MAGIC ^ h2a_pkg::MAGIC_W'(1 + $urandom % 16'hffff);
            end else begin
                exp_q.push_back(i);
            end
            word[h2a_pkg::IRQ_BIT] = d_irq[i];
            word[h2a_pkg::EOP_BIT] = d_eop[i];
            word[h2a_pkg::MAGIC_LSB +: h2a_pkg::MAGIC_W] = magic;
            // partial tail bytes get truncated by the engine
            word[h2a_pkg::LEN_LSB +: h2a_pkg::LEN_W] =
                h2a_pkg::LEN_W'(d_beats[i] * h2a_pkg::BEAT_BYTES + int'($urandom % 8));
            word[h2a_pkg::SRC_LSB +: h2a_pkg::ADDR_W] = d_src[i];
            word[h2a_pkg::ID_LSB +: h2a_pkg::ID_W]    = d_id[i];
            word[h2a_pkg::CH_LSB +: h2a_pkg::CH_W]    = d_ch[i];
            d_word[i] = word;
        end
        n_valid = exp_q.size();
    endtask

    ////////////////////////////////////////////////////////////
    // random stalls and host memory on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [h2a_pkg::ADDR_W-1:0] beat_addr;
        if (run) begin
            if (stall_cyc > 0) begin
                // long back pressure lets the read FIFO fill and stall the host
                m_axis_tready = 1'b0;
                stall_cyc--;
            end else begin
                m_axis_tready = ($urandom % 4) != 0;
                if ($urandom % 64 == 0) begin
                    stall_cyc = 16 + int'($urandom % 16);
                end
            end
            lcl_rd_ready  = ($urandom % 3) != 0;
            // resp noise on idle channels and an occasional answer on the valid one
            cmp_resp = h2a_pkg::NUM_CH'($urandom) & ~cmp_valid;
            if ($urandom % 3 == 0) begin
                cmp_resp = cmp_resp | cmp_valid;
            end
            lcl_rd_data_valid = 1'b0;
            lcl_rd_rsp_code   = 1'b0;
            if (host_q.size() > 0 && lcl_rd_rsp_ready && ($urandom % 4) != 0) begin
                beat_addr         = host_q.pop_front();
                lcl_rd_data_valid = 1'b1;
                lcl_rd_data       = mem_word(beat_addr);
                lcl_rd_rsp_code   = ($urandom % 16) == 0;
                // first errored beat of the descriptor
                if (lcl_rd_rsp_code && !exp_err) begin
                    exp_err      = 1'b1;
                    exp_err_addr = beat_addr;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // monitor sampling handshakes at the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic have;
        int   idx;
        if (run) begin
            have = (cur < n_valid);
            idx  = have ? exp_q[cur] : 0;
            // read FIFO fill follows host beats in and stream beats out
            check_equal(64'(lcl_rd_rsp_ready), 64'(rd_occ != h2a_pkg::RDATA_DEPTH),
                        "rsp_ready against read FIFO fill");
            check_equal(64'(m_axis_tvalid), 64'(rd_occ != 0),
                        "m_axis_tvalid against read FIFO fill");
            if (lcl_rd_valid && lcl_rd_ready) begin
                check_equal(64'(have && req_k < d_beats[idx]), 64'd1, "unexpected read request");
                check_equal(lcl_rd_ea, d_src[idx] + 64'(req_k * h2a_pkg::BEAT_BYTES),
                            "read address");
                check_equal(64'(lcl_rd_first), 64'(req_k == 0), "read first flag");
                check_equal(64'(lcl_rd_last), 64'(req_k == d_beats[idx] - 1), "read last flag");
                check_equal(64'(lcl_rd_axi_id), 64'({d_ch[idx], h2a_pkg::ENGINE_ID}), "read id");
                host_q.push_back(lcl_rd_ea);
                req_k++;
            end
            if (m_axis_tvalid && m_axis_tready) begin
                check_equal(64'(have && beat_k < d_beats[idx]), 64'd1, "unexpected stream beat");
                check_equal(m_axis_tdata,
                            mem_word(d_src[idx] + 64'(beat_k * h2a_pkg::BEAT_BYTES)),
                            "stream data");
                check_equal(64'(m_axis_tid), 64'(d_ch[idx]), "stream tid");
                check_equal(64'(m_axis_tlast), 64'(d_eop[idx] && beat_k == d_beats[idx] - 1),
                            "stream tlast");
                beat_k++;
            end
            if (lcl_rd_data_valid && lcl_rd_rsp_ready) begin
                rd_occ++;
            end
            if (m_axis_tvalid && m_axis_tready) begin
                rd_occ--;
            end
            if (cmp_valid != '0) begin
                check_equal(64'(have), 64'd1, "completion with no descriptor in flight");
                check_equal(64'(cmp_valid), 64'(h2a_pkg::NUM_CH'(1) << d_ch[idx]),
                            "completion channel");
                check_equal(64'(req_k), 64'(d_beats[idx]), "requests before completion");
                check_equal(64'(beat_k), 64'(d_beats[idx]), "beats before completion");
            end
            if ((cmp_valid & cmp_resp) != '0) begin
                check_equal(64'(cmp_data.dsc_id), 64'(d_id[idx]), "record id");
                check_equal(64'(cmp_data.irq), 64'(d_irq[idx]), "record irq");
                check_equal(64'(cmp_data.channel), 64'(d_ch[idx]), "record channel");
                check_equal(64'(cmp_data.complete), 64'd1, "record complete");
                check_equal(64'(cmp_data.error), 64'(exp_err), "record error");
                if (exp_err) begin
                    check_equal(cmp_data.err_addr, exp_err_addr, "record error address");
                end
                cur++;
                req_k        = 0;
                beat_k       = 0;
                exp_err      = 1'b0;
                exp_err_addr = '0;
                n_done++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: only %0d of %0d descriptors completed by %0t", n_done, n_valid, $time);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // reset and descriptor feed
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        void'($urandom(32'hd1b2));
        clk               = 1'b0;
        rst_n             = 1'b0;
        dsc_valid         = 1'b0;
        dsc_data          = '0;
        lcl_rd_ready      = 1'b0;
        lcl_rd_data_valid = 1'b0;
        lcl_rd_data       = '0;
        lcl_rd_rsp_code   = 1'b0;
        m_axis_tready     = 1'b0;
        cmp_resp          = '0;
        run               = 1'b0;
        n_done            = 0;
        cur               = 0;
        req_k             = 0;
        beat_k            = 0;
        rd_occ            = 0;
        stall_cyc         = 0;
        exp_err           = 1'b0;
        exp_err_addr      = '0;
        make_descriptors();
        repeat (10) @(posedge clk);
        @(negedge clk);
        // idle outputs under reset
        check_equal(64'(dsc_ready), 64'd1, "dsc_ready in reset");
        check_equal(64'(lcl_rd_valid), 64'd0, "lcl_rd_valid in reset");
        check_equal(64'(m_axis_tvalid), 64'd0, "m_axis_tvalid in reset");
        check_equal(64'(cmp_valid), 64'd0, "cmp_valid in reset");
        check_equal(64'(lcl_rd_rsp_ready), 64'd1, "lcl_rd_rsp_ready in reset");
        rst_n = 1'b1;
        @(posedge clk);
        run = 1'b1;
        @(negedge clk);
        for (i = 0; i < NUM_DSC; i++) begin
            repeat ($urandom % 3) @(negedge clk);
            dsc_valid = 1'b1;
            dsc_data  = d_word[i];
            // dsc_ready only moves on the rising edge
            while (!dsc_ready) @(negedge clk);
            @(negedge clk);
            dsc_valid = 1'b0;
        end
        wait (n_done == n_valid);
        // trailing bad descriptors must stay silent
        repeat (20) @(negedge clk);
        check_equal(64'(lcl_rd_valid), 64'd0, "lcl_rd_valid after last descriptor");
        check_equal(64'(m_axis_tvalid), 64'd0, "m_axis_tvalid after last descriptor");
        check_equal(64'(cmp_valid), 64'd0, "cmp_valid after last descriptor");
        check_equal(64'(dsc_ready), 64'd1, "dsc_ready after last descriptor");
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sim.f
h2a_pkg.sv
h2a_dsc_if.sv
h2a_fifo.sv
h2a_rd_dispatch.sv
h2a_st_writer.sv
h2a_cmp_ctrl.sv
h2a_st_engine.sv
h2a_st_engine_checker.sv
tb_h2a_st_engine.sv

//--- Makefile
# Verilator build and run for the host-to-stream DMA engine

VERILATOR  ?= verilator
TOP        ?= tb_h2a_st_engine
DUT_TOP    ?= h2a_st_engine
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
